//--- Makefile
TOP := wb_mem_tb

sim:
	verilator --binary --timing --timescale 1ns/100ps --top-module $(TOP) \
		-f verilog.f -o $(TOP)_sim
	@out="$$(./obj_dir/$(TOP)_sim 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- dv/wb_mem_tests.svh
`ifndef WB_MEM_TESTS_SVH
`define WB_MEM_TESTS_SVH

task automatic expect_ack(input string what, input logic ack, input logic err);
    compare_bit({what, " ack"}, 1'b1, ack);
    compare_bit({what, " err"}, 1'b0, err);
endtask

task automatic expect_err(input string what, input logic ack, input logic err);
    compare_bit({what, " ack"}, 1'b0, ack);
    compare_bit({what, " err"}, 1'b1, err);
endtask

// every word gets a known value so partial writes merge into defined data
task automatic preload_banks();
    wb_addr_t adr;
    logic     ack;
    logic     err;
    int       cycles;
    test_name = "preload_banks";
    for (int i = 0; i < `MEM0_WORDS + `MEM1_WORDS; i++) begin
        if (i < `MEM0_WORDS) begin
            adr = `MEM0_BASE + 32'(i * 4);
        end else begin
            adr = `MEM1_BASE + 32'((i - `MEM0_WORDS) * 4);
        end
        wb_write(adr, fill_word(adr), 4'hf, ack, err, cycles);
        expect_ack("preload write", ack, err);
        model_write(adr, fill_word(adr), 4'hf);
    end
endtask

task automatic test_word_rw();
    wb_addr_t    addrs [6];
    logic [31:0] r;
    wb_data_t    rdat;
    logic        ack;
    logic        err;
    int          cycles;
    test_name = "test_word_rw";
    addrs[0] = `MEM0_BASE;
    addrs[1] = `MEM0_BASE + 32'(`MEM0_WORDS * 2);  // middle word
    addrs[2] = `MEM0_BASE + 32'((`MEM0_WORDS - 1) * 4);
    addrs[3] = `MEM1_BASE;
    addrs[4] = `MEM1_BASE + 32'(`MEM1_WORDS * 2);
    addrs[5] = `MEM1_BASE + 32'((`MEM1_WORDS - 1) * 4);
    foreach (addrs[i]) begin
        rand_bits(32, r);
        wb_write(addrs[i], r, 4'hf, ack, err, cycles);
        expect_ack("word write", ack, err);
        model_write(addrs[i], r, 4'hf);
    end
    foreach (addrs[i]) begin
        wb_read(addrs[i], rdat, ack, err, cycles);
        expect_ack("word read", ack, err);
        compare_data("word read", model_read(addrs[i]), rdat);
    end
    bus_idle();
endtask

task automatic test_byte_lanes();
    wb_addr_t    base [2];
    wb_sel_t     sels [5];
    logic [31:0] r;
    wb_data_t    rdat;
    logic        ack;
    logic        err;
    int          cycles;
    test_name = "test_byte_lanes";
    base[0] = `MEM0_BASE + 32'h44;
    base[1] = `MEM1_BASE + 32'h84;
    sels = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0101};
    foreach (base[b]) begin
        wb_write(base[b], 32'h1122_3344, 4'hf, ack, err, cycles);
        expect_ack("pattern write", ack, err);
        model_write(base[b], 32'h1122_3344, 4'hf);
        foreach (sels[s]) begin
            rand_bits(32, r);
            wb_write(base[b], r, sels[s], ack, err, cycles);
            expect_ack("lane write", ack, err);
            model_write(base[b], r, sels[s]);
            wb_read(base[b], rdat, ack, err, cycles);
            expect_ack("lane read", ack, err);
            compare_data("merged word", model_read(base[b]), rdat);
        end
    end
    bus_idle();
endtask

task automatic test_latency();
    wb_addr_t addrs [2];
    wb_data_t rdat;
    logic     ack;
    logic     err;
    int       cycles;
    test_name = "test_latency";
    addrs[0] = `MEM0_BASE + 32'h14;
    addrs[1] = `MEM1_BASE + 32'h24;
    foreach (addrs[i]) begin
        bus_idle();
        wb_write(addrs[i], 32'h0f1e_2d3c, 4'hf, ack, err, cycles);
        model_write(addrs[i], 32'h0f1e_2d3c, 4'hf);
        compare_count("write latency", 1, cycles);
        wb_read(addrs[i], rdat, ack, err, cycles);  // straight after the write ack
        compare_count("read latency", 2, cycles);
        compare_data("read after write", model_read(addrs[i]), rdat);
    end
    bus_idle();
    wb_write(32'h0000_2000, 32'h1234_5678, 4'hf, ack, err, cycles);
    expect_err("unmapped write", ack, err);
    compare_count("error latency", 1, cycles);
    wb_read(32'h0000_3004, rdat, ack, err, cycles);
    compare_count("error latency on read", 1, cycles);
    bus_idle();
endtask

task automatic test_unmapped();
    wb_addr_t bad [2];
    wb_data_t rdat;
    logic     ack;
    logic     err;
    int       cycles;
    test_name = "test_unmapped";
    bad[0] = 32'h0000_2000;
    bad[1] = 32'h8000_0000;
    foreach (bad[i]) begin
        wb_write(bad[i], 32'hdead_beef, 4'hf, ack, err, cycles);
        expect_err("unmapped write", ack, err);
        wb_read(bad[i], rdat, ack, err, cycles);
        expect_err("unmapped read", ack, err);
        compare_data("unmapped read data", 32'h0, rdat);
    end
    // both bad addresses share their low bits with word 0 of each bank
    wb_read(`MEM0_BASE, rdat, ack, err, cycles);
    expect_ack("bank 0 read back", ack, err);
    compare_data("bank 0 word 0", model_read(`MEM0_BASE), rdat);
    wb_read(`MEM1_BASE, rdat, ack, err, cycles);
    expect_ack("bank 1 read back", ack, err);
    compare_data("bank 1 word 0", model_read(`MEM1_BASE), rdat);
    bus_idle();
endtask

task automatic test_random();
    logic [31:0] r;
    wb_addr_t    adr;
    wb_sel_t     sel;
    logic        we;
    wb_data_t    dat;
    wb_data_t    rdat;
    logic        ack;
    logic        err;
    int          cycles;
    test_name = "test_random";
    for (int n = 0; n < 200; n++) begin
        rand_bits(1, r);
        adr = r[0] ? `MEM1_BASE : `MEM0_BASE;
        rand_bits(10, r);
        adr = adr + {20'h0, r[9:0], 2'b00};  // offsets past the bank size alias
        rand_bits(4, r);
        sel = r[3:0];
        rand_bits(1, r);
        we = r[0];
        rand_bits(32, dat);
        rand_bits(2, r);
        if (r[1:0] == 2'b00) bus_idle();  // otherwise strobe stays high into the next request
        if (we) begin
            wb_write(adr, dat, sel, ack, err, cycles);
            expect_ack("random write", ack, err);
            model_write(adr, dat, sel);
        end else begin
            wb_read(adr, rdat, ack, err, cycles);
            expect_ack("random read", ack, err);
            compare_data("random read", model_read(adr), rdat);
        end
    end
    bus_idle();
    @(negedge clk);
    compare_count("response pulses", resp_count, ack_pulses + err_pulses);
endtask

`endif

//--- dv/wb_mem_tb.sv
`timescale 1ns/100ps

`include "wb_mem_defines.svh"

module wb_mem_tb
    import wb_mem_pkg::*;
();

    // preload takes about 770 cycles, the random test at most 4 per access,
    // the directed tests stay under 200, the rest is margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic     clk = 1'b0;
    logic     arst_n;
    wb_addr_t wb_adr;
    wb_data_t wb_wdat;
    wb_sel_t  wb_sel;
    logic     wb_we;
    logic     wb_cyc;
    logic     wb_stb;
    logic     wb_ack;
    logic     wb_err;
    wb_data_t wb_rdat;

    int          cycle_cnt  = 0;
    int          resp_count = 0;  // responses found by the bus tasks
    int          ack_pulses = 0;  // cycles with ack high, seen by the monitor
    int          err_pulses = 0;
    string       test_name  = "reset";
    logic [31:0] lfsr_state = 32'hd5216a8e;

    // expected bank contents, keyed by word index after alias folding
    wb_data_t model0 [int];
    wb_data_t model1 [int];

    always #5 clk = ~clk;

    wb_mem_top dut0 (
        .clk      (clk),
        .arst_n_i (arst_n),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_wdat),
        .wb_sel_i (wb_sel),
        .wb_we_i  (wb_we),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_ack_o (wb_ack),
        .wb_err_o (wb_err),
        .wb_dat_o (wb_rdat)
    );

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("simulation timed out after %0d cycles in %s", cycle_cnt, test_name);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    // a response held for two cycles would be counted twice here
    always @(negedge clk) begin
        if (wb_ack) ack_pulses++;
        if (wb_err) err_pulses++;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];  // taps 32 22 2 1
        return {s[30:0], fb};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // 0 or 1 for a bank, -1 for an unmapped address
    function automatic int bank_of(input wb_addr_t adr);
        wb_addr_t region;
        region = adr & `MEM_REGION_MASK;
        if (region == `MEM0_BASE) begin
            return 0;
        end else if (region == `MEM1_BASE) begin
            return 1;
        end
        return -1;
    endfunction

    function automatic int word_of(input wb_addr_t adr);
        int words;
        words = (bank_of(adr) == 1) ? `MEM1_WORDS : `MEM0_WORDS;
        return int'((adr & ~`MEM_REGION_MASK) >> 2) % words;  // aliases inside the region
    endfunction

    function automatic wb_data_t fill_word(input wb_addr_t adr);
        return adr ^ {adr[15:0], adr[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic wb_data_t model_read(input wb_addr_t adr);
        int idx;
        idx = word_of(adr);
        if (bank_of(adr) == 0 && model0.exists(idx)) return model0[idx];
        if (bank_of(adr) == 1 && model1.exists(idx)) return model1[idx];
        return '0;  // unmapped reads give zero
    endfunction

    task automatic model_write(input wb_addr_t adr, input wb_data_t dat, input wb_sel_t sel);
        wb_data_t word;
        word = model_read(adr);
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) word[8*b +: 8] = dat[8*b +: 8];
        end
        if (bank_of(adr) == 0) begin
            model0[word_of(adr)] = word;
        end else if (bank_of(adr) == 1) begin
            model1[word_of(adr)] = word;
        end
    endtask

    task automatic compare_data(input string what, input wb_data_t exp, input wb_data_t act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
            $display("Test failures found");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic compare_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %s %s: expected %b, actual %b", test_name, what, exp, act);
            $display("Test failures found");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic compare_count(input string what, input int exp, input int act);
        if (act != exp) begin
            $display("[FAIL] %s %s: expected %0d, actual %0d", test_name, what, exp, act);
            $display("Test failures found");
            $fatal(1, "count mismatch");
        end
    endtask

    // cycles are counted from the edge that first samples the request
    task automatic bus_cycle(input wb_addr_t adr, input wb_data_t wdat, input wb_sel_t sel,
                             input logic we, output wb_data_t rdat, output logic ack,
                             output logic err, output int cycles);
        @(posedge clk);
        wb_adr  <= adr;
        wb_wdat <= wdat;
        wb_sel  <= sel;
        wb_we   <= we;
        wb_cyc  <= 1'b1;
        wb_stb  <= 1'b1;
        @(posedge clk);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!wb_ack && !wb_err);
        rdat = wb_rdat;
        ack  = wb_ack;
        err  = wb_err;
        resp_count++;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t dat, input wb_sel_t sel,
                            output logic ack, output logic err, output int cycles);
        wb_data_t rdat;
        bus_cycle(adr, dat, sel, 1'b1, rdat, ack, err, cycles);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t rdat,
                           output logic ack, output logic err, output int cycles);
        bus_cycle(adr, 32'h0, 4'hf, 1'b0, rdat, ack, err, cycles);
    endtask

    task automatic bus_idle();
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    `include "wb_mem_tests.svh"

    initial begin
        arst_n  = 1'b0;
        wb_adr  = '0;
        wb_wdat = '0;
        wb_sel  = '0;
        wb_we   = 1'b0;
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        preload_banks();
        test_word_rw();
        test_byte_lanes();
        test_latency();
        test_unmapped();
        test_random();
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verilog
+incdir+dv
verilog/wb_mem_pkg.sv
verilog/soc_mem.sv
verilog/mem_wb.sv
verilog/wb_decoder.sv
verilog/wb_mem_top.sv
dv/wb_mem_tb.sv

//--- verilog/mem_wb.sv
`timescale 1ns/100ps

module mem_wb
    import wb_mem_pkg::*;
#(
    parameter int WORDS     = 256,
    parameter int ADR_WIDTH = 8
) (
    input  logic     clk,
    input  logic     arst_n_i,

    input  wb_addr_t wb_adr_i,
    input  wb_data_t wb_dat_i,
    input  wb_sel_t  wb_sel_i,
    input  logic     wb_we_i,
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,

    output logic     wb_ack_o,
    output wb_data_t wb_dat_o
);

    logic    access;     // a request this slave has not yet answered
    logic    read_pend;  // read data is in flight from the RAM
    wb_sel_t ram_wen;

    // while ack is high the master still holds the old request
    // so that strobe must not start a second access
    assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    assign ram_wen = wb_sel_i & {4{wb_we_i}};

    // a write is done in the RAM on the edge that samples it, so ack follows at once
    // a read needs one more edge for the registered RAM data, hence the pending flag
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            read_pend <= 1'b0;
            wb_ack_o  <= 1'b0;
        end else begin
            read_pend <= access & ~wb_we_i & ~read_pend;  // clears on the second read edge
            wb_ack_o  <= (access & wb_we_i) | read_pend;
        end
    end

    // during a read the RAM is enabled on both edges with the same address,
    // which only loads the same word twice
    soc_mem #(
        .WORDS     (WORDS),
        .ADR_WIDTH (ADR_WIDTH)
    ) u_ram (
        .clk     (clk),
        .ena_i   (access),
        .wen_i   (ram_wen),
        .addr_i  (wb_adr_i[ADR_WIDTH+1:2]),  // bits above the bank size are ignored
        .wdata_i (wb_dat_i),
        .rdata_o (wb_dat_o)
    );

endmodule

//--- verilog/soc_mem.sv
`timescale 1ns/100ps

module soc_mem
    import wb_mem_pkg::*;
#(
    parameter int WORDS     = 256,
    parameter int ADR_WIDTH = 8
) (
    input  logic                 clk,
    input  logic                 ena_i,
    input  wb_sel_t              wen_i,     // one write enable per byte lane
    input  logic [ADR_WIDTH-1:0] addr_i,    // word index, not a byte address
    input  wb_data_t             wdata_i,
    output wb_data_t             rdata_o
);

    wb_data_t mem [0:WORDS-1];

    // read and write share the single port
    // a write returns the old word on rdata_o, which the adapter never uses
    always_ff @(posedge clk) begin
        if (ena_i) begin
            rdata_o <= mem[addr_i];
            for (int b = 0; b < 4; b++) begin
                if (wen_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];  // only the enabled lane
                end
            end
        end
    end

endmodule

//--- verilog/wb_decoder.sv
`timescale 1ns/100ps

`include "wb_mem_defines.svh"

module wb_decoder
    import wb_mem_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,

    // master side
    input  wb_addr_t wb_adr_i,
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,
    output logic     wb_ack_o,
    output logic     wb_err_o,
    output wb_data_t wb_dat_o,

    // bank 0
    output logic     s0_cyc_o,
    output logic     s0_stb_o,
    input  logic     s0_ack_i,
    input  wb_data_t s0_dat_i,

    // bank 1
    output logic     s1_cyc_o,
    output logic     s1_stb_o,
    input  logic     s1_ack_i,
    input  wb_data_t s1_dat_i
);

    wb_addr_t region;
    logic     hit0;
    logic     hit1;
    logic     miss;
    logic     valid;
    logic     err_q;
    logic     bank1_q;  // last request went to bank 1
    logic     miss_q;   // last request hit no bank

    assign region = wb_adr_i & `MEM_REGION_MASK;
    assign hit0   = (region == `MEM0_BASE);
    assign hit1   = (region == `MEM1_BASE);
    assign miss   = ~hit0 & ~hit1;
    assign valid  = wb_cyc_i & wb_stb_i;

    // only the selected bank sees the cycle, the other one idles
    assign s0_cyc_o = wb_cyc_i & hit0;
    assign s0_stb_o = wb_stb_i & hit0;
    assign s1_cyc_o = wb_cyc_i & hit1;
    assign s1_stb_o = wb_stb_i & hit1;

    // At most one bank is addressed at a time, so a plain OR of the acks is enough.
    assign wb_ack_o = s0_ack_i | s1_ack_i;
    assign wb_err_o = err_q;

    // the request stays stable until its answer, so the choice
    // taken on the sampling edge still holds when the ack arrives
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bank1_q <= 1'b0;
            miss_q  <= 1'b0;
        end else if (valid) begin
            bank1_q <= hit1;
            miss_q  <= miss;
        end
    end

    // unmapped access gets err one cycle later, once per request
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_q <= 1'b0;
        end else begin
            err_q <= valid & miss & ~err_q;  // a strobe held across err is not answered again
        end
    end

    always_comb begin
        if (miss_q) begin
            wb_dat_o = '0;              // error responses carry no data
        end else if (bank1_q) begin
            wb_dat_o = s1_dat_i;
        end else begin
            wb_dat_o = s0_dat_i;
        end
    end

endmodule

//--- verilog/wb_mem_defines.svh
`ifndef WB_MEM_DEFINES_SVH
`define WB_MEM_DEFINES_SVH

// bank depths in 32-bit words

// bank 0 holds 1 KB of data RAM
`define MEM0_WORDS 256

// bank 1 holds 512 bytes
`define MEM1_WORDS 128

// each bank owns one 4 KB region of the byte address space
`define MEM0_BASE 32'h0000_0000
`define MEM1_BASE 32'h0000_1000

// keeps the upper address bits that name a 4 KB region
// a bank smaller than its region shows up again every bank size inside it
`define MEM_REGION_MASK 32'hFFFF_F000

`endif

//--- verilog/wb_mem_pkg.sv
package wb_mem_pkg;

    // byte address as the master drives it
    typedef logic [31:0] wb_addr_t;

    // one bus data word, also the RAM word width
    typedef logic [31:0] wb_data_t;

    // byte lane select, bit n enables data bits 8n+7 down to 8n
    typedef logic [3:0] wb_sel_t;

endpackage

//--- verilog/wb_mem_top.sv
`timescale 1ns/100ps

`include "wb_mem_defines.svh"

module wb_mem_top
    import wb_mem_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n_i,

    input  wb_addr_t wb_adr_i,
    input  wb_data_t wb_dat_i,
    input  wb_sel_t  wb_sel_i,
    input  logic     wb_we_i,
    input  logic     wb_cyc_i,
    input  logic     wb_stb_i,

    output logic     wb_ack_o,
    output logic     wb_err_o,
    output wb_data_t wb_dat_o
);

    localparam int MEM0_AW = $clog2(`MEM0_WORDS);
    localparam int MEM1_AW = $clog2(`MEM1_WORDS);

    logic     s0_cyc;
    logic     s0_stb;
    logic     s0_ack;
    wb_data_t s0_dat;
    logic     s1_cyc;
    logic     s1_stb;
    logic     s1_ack;
    wb_data_t s1_dat;

    wb_decoder u_dec (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_adr_i (wb_adr_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_ack_o (wb_ack_o),
        .wb_err_o (wb_err_o),
        .wb_dat_o (wb_dat_o),
        .s0_cyc_o (s0_cyc),
        .s0_stb_o (s0_stb),
        .s0_ack_i (s0_ack),
        .s0_dat_i (s0_dat),
        .s1_cyc_o (s1_cyc),
        .s1_stb_o (s1_stb),
        .s1_ack_i (s1_ack),
        .s1_dat_i (s1_dat)
    );

    // address, write data, sel and we go straight to both banks
    // only cyc and stb are steered by the decoder
    mem_wb #(
        .WORDS     (`MEM0_WORDS),
        .ADR_WIDTH (MEM0_AW)
    ) u_bank0 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_we_i  (wb_we_i),
        .wb_cyc_i (s0_cyc),
        .wb_stb_i (s0_stb),
        .wb_ack_o (s0_ack),
        .wb_dat_o (s0_dat)
    );

    mem_wb #(
        .WORDS     (`MEM1_WORDS),
        .ADR_WIDTH (MEM1_AW)
    ) u_bank1 (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_we_i  (wb_we_i),
        .wb_cyc_i (s1_cyc),
        .wb_stb_i (s1_stb),
        .wb_ack_o (s1_ack),
        .wb_dat_o (s1_dat)
    );

endmodule
